//--- common/wb_pkg.sv
package wb_pkg;

	localparam int XLEN = 64;

	typedef logic [XLEN-1:0] xlen_t;
	typedef logic [4:0]      reg_addr_t;
	typedef logic [11:0]     csr_addr_t;

	localparam csr_addr_t CSR_MSTATUS  = 12'h300;
	localparam csr_addr_t CSR_MIE      = 12'h304;
	localparam csr_addr_t CSR_MTVEC    = 12'h305;
	localparam csr_addr_t CSR_MSCRATCH = 12'h340;
	localparam csr_addr_t CSR_MEPC     = 12'h341;
	localparam csr_addr_t CSR_MCAUSE   = 12'h342;

	localparam xlen_t CAUSE_ECALL_M = 64'd11;
	localparam xlen_t CAUSE_TIMER_M = 64'h8000_0000_0000_0007;

	localparam int MSTATUS_MIE  = 3;
	localparam int MSTATUS_MPIE = 7;
	localparam int MIE_MTIE     = 7;

	// Only MIE and MPIE exist in this machine-mode-only mstatus
	localparam xlen_t MSTATUS_WMASK = (xlen_t'(1) << MSTATUS_MIE) | (xlen_t'(1) << MSTATUS_MPIE);

	typedef enum logic [1:0] {
		WB_NONE,
		WB_LOAD,
		WB_ALU
	} wb_sel_e;

	typedef enum logic [2:0] {
		CSR_OP_NONE,
		CSR_OP_RW,
		CSR_OP_RS,
		CSR_OP_RC,
		CSR_OP_ECALL,
		CSR_OP_MRET
	} csr_op_e;

	typedef struct packed {
		logic      valid;
		xlen_t     pc;
		xlen_t     load_data;
		xlen_t     alu_res; // Also the CSR operand
		wb_sel_e   wb_sel;
		logic      rd_en;
		reg_addr_t rd_addr;
		csr_op_e   csr_op;
		csr_addr_t csr_addr;
	} retire_t;

	typedef struct packed {
		logic      we;
		csr_addr_t addr;
		xlen_t     wdata;
		logic      trap_enter;
		xlen_t     cause;
		xlen_t     epc;
		logic      mret;
	} csr_req_t;

	typedef struct packed {
		xlen_t rdata;
		xlen_t mtvec;
		xlen_t mepc;
		logic  irq_pending;
	} csr_rsp_t;

	typedef struct packed {
		logic      en;
		reg_addr_t addr;
		xlen_t     data;
	} gpr_wr_t;

	typedef struct packed {
		logic  valid; // Doubles as flush
		xlen_t pc;
	} redirect_t;

endpackage

//--- wbu/wb_stage.sv
`timescale 1ns/1ns

module wb_stage (
	input  wb_pkg::retire_t   retire_i,
	input  wb_pkg::csr_rsp_t  csr_rsp_i,
	output wb_pkg::csr_req_t  csr_req_o,
	output wb_pkg::gpr_wr_t   gpr_wr_o,
	output wb_pkg::redirect_t redirect_o
);
	import wb_pkg::*;

	logic  take_irq;
	logic  take_ecall;
	logic  take_mret;
	logic  take_trap;
	logic  is_csr;
	xlen_t csr_wdata;
	xlen_t rd_data;

	// Priority: interrupt, ecall, mret, CSR access, plain write
	always_comb begin
		take_irq   = retire_i.valid && csr_rsp_i.irq_pending;
		take_ecall = retire_i.valid && !take_irq && (retire_i.csr_op == CSR_OP_ECALL);
		take_mret  = retire_i.valid && !take_irq && (retire_i.csr_op == CSR_OP_MRET);
		take_trap  = take_irq || take_ecall;
		is_csr     = retire_i.valid && !take_irq &&
			((retire_i.csr_op == CSR_OP_RW) ||
			 (retire_i.csr_op == CSR_OP_RS) ||
			 (retire_i.csr_op == CSR_OP_RC));
	end

	always_comb begin
		case (retire_i.csr_op)
			CSR_OP_RW: csr_wdata = retire_i.alu_res;
			CSR_OP_RS: csr_wdata = csr_rsp_i.rdata | retire_i.alu_res;
			CSR_OP_RC: csr_wdata = csr_rsp_i.rdata & ~retire_i.alu_res;
			default:   csr_wdata = csr_rsp_i.rdata;
		endcase
	end

	always_comb begin
		if (is_csr) begin
			rd_data = csr_rsp_i.rdata; // Old CSR value
		end else begin
			case (retire_i.wb_sel)
				WB_LOAD: rd_data = retire_i.load_data;
				WB_ALU:  rd_data = retire_i.alu_res;
				default: rd_data = '0;
			endcase
		end
	end

	always_comb begin
		csr_req_o.we         = is_csr;
		csr_req_o.addr       = retire_i.csr_addr;
		csr_req_o.wdata      = csr_wdata;
		csr_req_o.trap_enter = take_trap;
		csr_req_o.cause      = take_irq ? CAUSE_TIMER_M : CAUSE_ECALL_M;
		csr_req_o.epc        = retire_i.pc;
		csr_req_o.mret       = take_mret;
	end

	// Redirecting beat never writes rd
	always_comb begin
		gpr_wr_o.en   = retire_i.valid && retire_i.rd_en && !take_trap && !take_mret;
		gpr_wr_o.addr = retire_i.rd_addr;
		gpr_wr_o.data = rd_data;
	end

	always_comb begin
		redirect_o.valid = take_trap || take_mret;
		if (take_trap) begin
			redirect_o.pc = {csr_rsp_i.mtvec[XLEN-1:2], 2'b00}; // Direct mode only
		end else begin
			redirect_o.pc = csr_rsp_i.mepc;
		end
	end

endmodule

//--- wbu/csr_file.sv
`timescale 1ns/1ns

module csr_file (
	input  logic             clk,
	input  logic             rst_i,
	input  logic             timer_irq_i,
	input  wb_pkg::csr_req_t req_i,
	output wb_pkg::csr_rsp_t rsp_o
);
	import wb_pkg::*;

	xlen_t mstatus;
	xlen_t mie;
	xlen_t mtvec;
	xlen_t mscratch;
	xlen_t mepc;
	xlen_t mcause;
	xlen_t rdata;

	always_comb begin
		case (req_i.addr)
			CSR_MSTATUS:  rdata = mstatus;
			CSR_MIE:      rdata = mie;
			CSR_MTVEC:    rdata = mtvec;
			CSR_MSCRATCH: rdata = mscratch;
			CSR_MEPC:     rdata = mepc;
			CSR_MCAUSE:   rdata = mcause;
			default:      rdata = '0; // Unimplemented
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			mstatus  <= '0;
			mie      <= '0;
			mtvec    <= '0;
			mscratch <= '0;
			mepc     <= '0;
			mcause   <= '0;
		end else if (req_i.trap_enter) begin
			mepc                  <= req_i.epc;
			mcause                <= req_i.cause;
			mstatus[MSTATUS_MPIE] <= mstatus[MSTATUS_MIE];
			mstatus[MSTATUS_MIE]  <= 1'b0;
		end else if (req_i.mret) begin
			mstatus[MSTATUS_MIE]  <= mstatus[MSTATUS_MPIE];
			mstatus[MSTATUS_MPIE] <= 1'b1;
		end else if (req_i.we) begin
			case (req_i.addr)
				CSR_MSTATUS:  mstatus  <= req_i.wdata & MSTATUS_WMASK;
				CSR_MIE:      mie      <= req_i.wdata;
				CSR_MTVEC:    mtvec    <= req_i.wdata;
				CSR_MSCRATCH: mscratch <= req_i.wdata;
				CSR_MEPC:     mepc     <= req_i.wdata;
				CSR_MCAUSE:   mcause   <= req_i.wdata;
				default:      ; // Write ignored
			endcase
		end
	end

	always_comb begin
		rsp_o.rdata       = rdata;
		rsp_o.mtvec       = mtvec;
		rsp_o.mepc        = mepc;
		rsp_o.irq_pending = mstatus[MSTATUS_MIE] && mie[MIE_MTIE] && timer_irq_i;
	end

endmodule

//--- source/gpr_file.sv
`timescale 1ns/1ns

module gpr_file #(
	parameter int NUM_REGS = 32
) (
	input  logic              clk,
	input  logic              rst_i,
	input  wb_pkg::gpr_wr_t   wr_i,
	input  wb_pkg::reg_addr_t rs_addr_i,
	output wb_pkg::xlen_t     rs_data_o
);
	import wb_pkg::*;

	// No storage behind x0
	xlen_t regs [1:NUM_REGS-1];

	logic wr_hit;
	logic rd_hit;

	always_comb begin
		wr_hit = wr_i.en && (wr_i.addr != '0) && (wr_i.addr < NUM_REGS);
		rd_hit = (rs_addr_i != '0) && (rs_addr_i < NUM_REGS);
	end

	always_ff @(posedge clk) begin
		if (rst_i) begin
			for (int i = 1; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wr_hit) begin
			regs[wr_i.addr] <= wr_i.data;
		end
	end

	always_comb begin
		if (rd_hit) begin
			rs_data_o = regs[rs_addr_i];
		end else begin
			rs_data_o = '0; // x0 or beyond RV64E range
		end
	end

endmodule

//--- source/wb_top.sv
`timescale 1ns/1ns

module wb_top #(
	parameter int NUM_REGS = 32
) (
	input  logic              clk,
	input  logic              rst_i,
	input  wb_pkg::retire_t   retire_i,
	input  logic              timer_irq_i,
	input  wb_pkg::reg_addr_t rs_addr_i,
	output wb_pkg::xlen_t     rs_data_o,
	output wb_pkg::redirect_t redirect_o,
	output wb_pkg::gpr_wr_t   fwd_o
);
	import wb_pkg::*;

	csr_req_t csr_req;
	csr_rsp_t csr_rsp;
	gpr_wr_t  gpr_wr;

	wb_stage wb_stage_i (
		.retire_i   (retire_i),
		.csr_rsp_i  (csr_rsp),
		.csr_req_o  (csr_req),
		.gpr_wr_o   (gpr_wr),
		.redirect_o (redirect_o)
	);

	csr_file csr_file_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.timer_irq_i (timer_irq_i),
		.req_i       (csr_req),
		.rsp_o       (csr_rsp)
	);

	gpr_file #(
		.NUM_REGS (NUM_REGS)
	) gpr_file_i (
		.clk       (clk),
		.rst_i     (rst_i),
		.wr_i      (gpr_wr),
		.rs_addr_i (rs_addr_i),
		.rs_data_o (rs_data_o)
	);

	assign fwd_o = gpr_wr; // Forward to decode

endmodule

//--- sim/wb_chk.sv
`timescale 1ns/1ns

module wb_chk (
	input logic              clk,
	input logic              rst_i,
	input wb_pkg::retire_t   retire_i,
	input wb_pkg::reg_addr_t rs_addr_i,
	input wb_pkg::xlen_t     rs_data_i,
	input wb_pkg::redirect_t redirect_i,
	input wb_pkg::gpr_wr_t   fwd_i
);

	int unsigned fail_count = 0; // Failed assertions so far

	// Trap or return never writes rd
	no_wr_on_redirect: assert property (@(posedge clk) disable iff (rst_i)
		redirect_i.valid |-> !fwd_i.en)
		else begin
			fail_count++;
			$error("register write in a redirect cycle");
		end

	redirect_needs_beat: assert property (@(posedge clk) disable iff (rst_i)
		redirect_i.valid |-> retire_i.valid)
		else begin
			fail_count++;
			$error("redirect without a valid retire beat");
		end

	x0_reads_zero: assert property (@(posedge clk) disable iff (rst_i)
		(rs_addr_i == '0) |-> (rs_data_i == '0))
		else begin
			fail_count++;
			$error("x0 read back nonzero");
		end

endmodule

bind wb_top wb_chk wb_chk_i (
	.clk        (clk),
	.rst_i      (rst_i),
	.retire_i   (retire_i),
	.rs_addr_i  (rs_addr_i),
	.rs_data_i  (rs_data_o),
	.redirect_i (redirect_o),
	.fwd_i      (fwd_o)
);

//--- sim/wb_tb.sv
`timescale 1ns/1ns

module wb_tb;
	import wb_pkg::*;

	localparam int RESET_CYCLES = 4;
	localparam int RANDOM_BEATS = 400;
	localparam int TOTAL_BEATS  = 28 + RANDOM_BEATS + 2; // Directed, random, tail
	localparam int CYCLE_LIMIT  = (RESET_CYCLES + TOTAL_BEATS) * 3 / 2;

	logic      clk;
	logic      rst_i;
	retire_t   retire;
	logic      timer_irq;
	reg_addr_t rs_addr;
	xlen_t     rs_data;
	redirect_t redirect;
	gpr_wr_t   fwd;

	xlen_t     mregs [32];
	xlen_t     mcsr [4096]; // Indexed by CSR address
	xlen_t     next_pc;
	csr_addr_t csr_pool [7];
	string     group;
	string     test_name;
	int        cycles;

	wb_top #(
		.NUM_REGS (32)
	) dut_i (
		.clk         (clk),
		.rst_i       (rst_i),
		.retire_i    (retire),
		.timer_irq_i (timer_irq),
		.rs_addr_i   (rs_addr),
		.rs_data_o   (rs_data),
		.redirect_o  (redirect),
		.fwd_o       (fwd)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic fail_run();
		$display("Done: errors found");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic cmp_xlen(input xlen_t exp, input xlen_t act);
		if (act !== exp) begin
			$display("ERR %s read port: expected %h, actual %h", test_name, exp, act);
			fail_run();
		end
	endtask

	task automatic cmp_redirect(input redirect_t exp, input redirect_t act);
		if (act.valid !== exp.valid || (exp.valid && act.pc !== exp.pc)) begin
			$display("ERR %s redirect: expected %b/%h, actual %b/%h", test_name,
				exp.valid, exp.pc, act.valid, act.pc);
			fail_run();
		end
	endtask

	task automatic cmp_wr(input gpr_wr_t exp, input gpr_wr_t act);
		if (act.en !== exp.en ||
			(exp.en && (act.addr !== exp.addr || act.data !== exp.data))) begin
			$display("ERR %s reg write: expected %b/x%0d/%h, actual %b/x%0d/%h", test_name,
				exp.en, exp.addr, exp.data, act.en, act.addr, act.data);
			fail_run();
		end
	endtask

	function automatic logic csr_known(input csr_addr_t a);
		return a == CSR_MSTATUS || a == CSR_MIE || a == CSR_MTVEC ||
			a == CSR_MSCRATCH || a == CSR_MEPC || a == CSR_MCAUSE;
	endfunction

	function automatic void ref_step(input retire_t b, input logic timer,
			output redirect_t exp_rd, output gpr_wr_t exp_wr);
		logic  irq;
		xlen_t old;
		xlen_t nv;
		irq    = mcsr[CSR_MSTATUS][MSTATUS_MIE] && mcsr[CSR_MIE][MIE_MTIE] && timer;
		old    = mcsr[b.csr_addr];
		exp_rd = '0;
		exp_wr = '0;
		if (!b.valid) begin
			return;
		end
		if (irq || b.csr_op == CSR_OP_ECALL) begin
			exp_rd.valid     = 1'b1;
			exp_rd.pc        = mcsr[CSR_MTVEC] & ~xlen_t'(3); // Direct mode base
			mcsr[CSR_MEPC]   = b.pc;
			mcsr[CSR_MCAUSE] = irq ? CAUSE_TIMER_M : CAUSE_ECALL_M;
			mcsr[CSR_MSTATUS][MSTATUS_MPIE] = mcsr[CSR_MSTATUS][MSTATUS_MIE];
			mcsr[CSR_MSTATUS][MSTATUS_MIE]  = 1'b0;
		end else if (b.csr_op == CSR_OP_MRET) begin
			exp_rd.valid = 1'b1;
			exp_rd.pc    = mcsr[CSR_MEPC];
			mcsr[CSR_MSTATUS][MSTATUS_MIE]  = mcsr[CSR_MSTATUS][MSTATUS_MPIE];
			mcsr[CSR_MSTATUS][MSTATUS_MPIE] = 1'b1;
		end else begin
			exp_wr.en   = b.rd_en;
			exp_wr.addr = b.rd_addr;
			case (b.csr_op)
				CSR_OP_RW: nv = b.alu_res;
				CSR_OP_RS: nv = old | b.alu_res;
				CSR_OP_RC: nv = old & ~b.alu_res;
				default:   nv = old;
			endcase
			if (b.csr_op != CSR_OP_NONE) begin
				exp_wr.data = old;
				if (csr_known(b.csr_addr)) begin
					// Only MIE and MPIE exist in mstatus
					mcsr[b.csr_addr] = (b.csr_addr == CSR_MSTATUS) ? nv & 64'h88 : nv;
				end
			end else begin
				exp_wr.data = (b.wb_sel == WB_LOAD) ? b.load_data :
					(b.wb_sel == WB_ALU) ? b.alu_res : xlen_t'(0);
			end
			if (b.rd_en && b.rd_addr != 0) begin
				mregs[b.rd_addr] = exp_wr.data;
			end
		end
	endfunction

	function automatic retire_t mk_beat(input csr_op_e op, input csr_addr_t addr,
			input wb_sel_e sel, input reg_addr_t rd, input xlen_t val);
		retire_t b;
		b           = '0;
		b.valid     = 1'b1;
		b.csr_op    = op;
		b.csr_addr  = addr;
		b.wb_sel    = sel;
		b.rd_en     = 1'b1;
		b.rd_addr   = rd;
		b.alu_res   = val;
		b.load_data = ~val; // Wrong source shows as a mismatch
		return b;
	endfunction

	task automatic drive(input retire_t b, input logic timer, input reg_addr_t rs);
		@(posedge clk);
		b.pc = next_pc;
		next_pc = next_pc + 4;
		retire    <= b;
		timer_irq <= timer;
		rs_addr   <= rs;
		test_name <= group;
	endtask

	// Outputs settle before the falling edge
	initial begin : compare
		redirect_t exp_rd;
		gpr_wr_t   exp_wr;
		forever begin
			@(negedge clk);
			if (dut_i.wb_chk_i.fail_count != 0) begin
				$display("A bound assertion on the write-back stage failed");
				fail_run();
			end
			if (!rst_i) begin
				cmp_xlen(mregs[rs_addr], rs_data); // Model still before this beat
				ref_step(retire, timer_irq, exp_rd, exp_wr);
				cmp_redirect(exp_rd, redirect);
				cmp_wr(exp_wr, fwd);
			end
		end
	end

	initial begin
		cycles = 0;
		forever begin
			@(posedge clk);
			cycles++;
			if (cycles > CYCLE_LIMIT) begin
				$display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
				fail_run();
			end
		end
	end

	initial begin
		retire_t b;
		void'($urandom(32'h3b04b0d6));
		rst_i     = 1'b1;
		retire    = '0;
		timer_irq = 1'b0;
		rs_addr   = '0;
		next_pc   = 64'h8000_0000;
		group     = "reset";
		csr_pool  = '{CSR_MSTATUS, CSR_MIE, CSR_MTVEC, CSR_MSCRATCH, CSR_MEPC, CSR_MCAUSE,
			12'h7c0};
		foreach (mregs[i]) begin
			mregs[i] = '0;
		end
		foreach (mcsr[i]) begin
			mcsr[i] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		rst_i <= 1'b0;

		group = "gpr_write";
		drive(mk_beat(CSR_OP_NONE, '0, WB_ALU, 5'd5, 64'h1111_2222_3333_4444), 1'b0, 5'd0);
		drive(mk_beat(CSR_OP_NONE, '0, WB_LOAD, 5'd6, 64'hdead_beef_0000_0001), 1'b0, 5'd5);
		drive(mk_beat(CSR_OP_NONE, '0, WB_ALU, 5'd0, 64'hffff), 1'b0, 5'd6);
		b = mk_beat(CSR_OP_NONE, '0, WB_ALU, 5'd7, 64'h77);
		b.rd_en = 1'b0;
		drive(b, 1'b0, 5'd0);
		drive('0, 1'b0, 5'd7);

		group = "csr_access";
		drive(mk_beat(CSR_OP_RW, CSR_MSCRATCH, WB_ALU, 5'd8, 64'ha5a5), 1'b0, 5'd0);
		drive(mk_beat(CSR_OP_RS, CSR_MSCRATCH, WB_ALU, 5'd9, 64'h0f00), 1'b0, 5'd8);
		drive(mk_beat(CSR_OP_RC, CSR_MSCRATCH, WB_ALU, 5'd10, 64'h00a5), 1'b0, 5'd9);
		drive(mk_beat(CSR_OP_RW, CSR_MTVEC, WB_ALU, 5'd11, 64'h1000), 1'b0, 5'd10);
		drive(mk_beat(CSR_OP_RS, CSR_MTVEC, WB_ALU, 5'd12, 64'h2000), 1'b0, 5'd11);
		drive(mk_beat(CSR_OP_RC, CSR_MTVEC, WB_ALU, 5'd13, 64'h1000), 1'b0, 5'd12);
		drive(mk_beat(CSR_OP_RS, CSR_MSCRATCH, WB_ALU, 5'd25, 64'h0), 1'b0, 5'd13);

		group = "ecall";
		drive(mk_beat(CSR_OP_ECALL, '0, WB_ALU, 5'd14, 64'h1), 1'b0, 5'd25);
		drive(mk_beat(CSR_OP_RS, CSR_MEPC, WB_ALU, 5'd15, 64'h0), 1'b0, 5'd14);
		drive(mk_beat(CSR_OP_RS, CSR_MCAUSE, WB_ALU, 5'd16, 64'h0), 1'b0, 5'd15);

		group = "timer_irq";
		drive(mk_beat(CSR_OP_RS, CSR_MIE, WB_ALU, 5'd0, 64'h80), 1'b1, 5'd16);
		drive(mk_beat(CSR_OP_NONE, '0, WB_ALU, 5'd17, 64'h5), 1'b1, 5'd0);
		drive(mk_beat(CSR_OP_RW, CSR_MSTATUS, WB_ALU, 5'd0, 64'h8), 1'b1, 5'd17);
		drive(mk_beat(CSR_OP_NONE, '0, WB_ALU, 5'd18, 64'h6), 1'b1, 5'd0);
		drive(mk_beat(CSR_OP_RS, CSR_MCAUSE, WB_ALU, 5'd19, 64'h0), 1'b1, 5'd18);

		group = "mret";
		drive(mk_beat(CSR_OP_MRET, '0, WB_ALU, 5'd20, 64'h0), 1'b1, 5'd19);
		drive(mk_beat(CSR_OP_NONE, '0, WB_ALU, 5'd21, 64'h7), 1'b1, 5'd20);
		drive(mk_beat(CSR_OP_RC, CSR_MIE, WB_ALU, 5'd0, 64'h80), 1'b0, 5'd21);
		drive(mk_beat(CSR_OP_MRET, '0, WB_ALU, 5'd0, 64'h0), 1'b0, 5'd0);
		drive(mk_beat(CSR_OP_NONE, '0, WB_ALU, 5'd22, 64'h8), 1'b1, 5'd0);

		group = "unknown_csr";
		drive(mk_beat(CSR_OP_RW, 12'h7c0, WB_ALU, 5'd23, 64'h55), 1'b0, 5'd22);
		drive(mk_beat(CSR_OP_RS, 12'h7c0, WB_ALU, 5'd24, 64'h0), 1'b0, 5'd23);
		drive('0, 1'b0, 5'd24);

		group = "random";
		repeat (RANDOM_BEATS) begin
			b = mk_beat(csr_op_e'($urandom % 6), csr_pool[$urandom % 7],
				wb_sel_e'($urandom % 3), $urandom % 32, {$urandom, $urandom});
			b.valid     = ($urandom % 8) != 0;
			b.rd_en     = ($urandom % 4) != 0;
			b.load_data = {$urandom, $urandom};
			drive(b, $urandom % 2, $urandom % 32);
		end
		drive('0, 1'b0, 5'd0);
		drive('0, 1'b0, 5'd0);
		@(posedge clk);
		@(negedge clk);
		if (dut_i.wb_chk_i.fail_count == 0) begin
			$display("Done: no errors");
			$finish;
		end else begin
			fail_run();
		end
	end

endmodule

//--- project.f
common/wb_pkg.sv
wbu/wb_stage.sv
wbu/csr_file.sv
source/gpr_file.sv
source/wb_top.sv
sim/wb_chk.sv
sim/wb_tb.sv

//--- Bender.yml
package:
  name: wb_stage

sources:
  - common/wb_pkg.sv
  - wbu/wb_stage.sv
  - wbu/csr_file.sv
  - source/gpr_file.sv
  - source/wb_top.sv
  - target: simulation
    files:
      - sim/wb_chk.sv
      - sim/wb_tb.sv
